//--- Bender.yml
package:
  name: fmul

sources:
  - logic/fmul_pkg.sv
  - logic/fmul_stream_if.sv
  - logic/fmul_flow_stage.sv
  - logic/fmul_exponent.sv
  - logic/fmul_operation.sv
  - logic/fmul_normalize.sv
  - logic/fmul_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/fmul_tb.sv

//--- build.f
+incdir+tests
logic/fmul_pkg.sv
logic/fmul_stream_if.sv
logic/fmul_flow_stage.sv
logic/fmul_exponent.sv
logic/fmul_operation.sv
logic/fmul_normalize.sv
logic/fmul_top.sv
tests/fmul_tb.sv

//--- logic/fmul_exponent.sv
module fmul_exponent
    import fmul_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input logic clk,
    input logic rst_n,

    fmul_stream_if.in  exponent_cmd,
    fmul_stream_if.out operation_cmd
);

    fmul_stream_if #(.T(fmul_operation_cmd_t)) next_operation_cmd ();

    logic [31:0]         op_a;
    logic [31:0]         op_b;
    fmul_class_t         class_a;
    fmul_class_t         class_b;
    logic                any_inf;
    logic                any_zero;
    fmul_operation_cmd_t cmd;

    assign op_a = exponent_cmd.payload.a;
    assign op_b = exponent_cmd.payload.b;

    assign class_a  = fmul_classify(op_a);
    assign class_b  = fmul_classify(op_b);
    assign any_inf  = (class_a == FMUL_CLASS_INF) || (class_b == FMUL_CLASS_INF);
    assign any_zero = (class_a == FMUL_CLASS_ZERO) || (class_b == FMUL_CLASS_ZERO);

    always_comb begin
        cmd.sign  = op_a[31] ^ op_b[31];
        // biased result exponent before normalization
        cmd.exp   = FMUL_EXP_W'(op_a[30:23]) + FMUL_EXP_W'(op_b[30:23])
                  - FMUL_EXP_W'(FMUL_BIAS);
        cmd.sig_a = fmul_significand(op_a);
        cmd.sig_b = fmul_significand(op_b);
        cmd.tag   = exponent_cmd.payload.tag;

        cmd.special = FMUL_SPECIAL_NONE;
        cmd.invalid = 1'b0;
        if (class_a == FMUL_CLASS_NAN || class_b == FMUL_CLASS_NAN || (any_inf && any_zero)) begin
            cmd.special = FMUL_SPECIAL_NAN;
            cmd.invalid = 1'b1;
        end else if (any_inf) begin
            cmd.special = FMUL_SPECIAL_INF;
        end else if (any_zero) begin
            cmd.special = FMUL_SPECIAL_ZERO;
        end
    end

    assign next_operation_cmd.valid   = exponent_cmd.valid;
    assign next_operation_cmd.payload = cmd;
    assign exponent_cmd.ready         = next_operation_cmd.ready;

    fmul_flow_stage #(
        .T(fmul_operation_cmd_t),
        .MODE(OUTPUT_REGISTER_MODE)
    ) output_stage (
        .clk,
        .rst_n,
        .stream_in(next_operation_cmd),
        .stream_out(operation_cmd)
    );

endmodule

//--- logic/fmul_flow_stage.sv
module fmul_flow_stage #(
    parameter type T    = logic,
    parameter int  MODE = 1
)(
    input logic clk,
    input logic rst_n,

    fmul_stream_if.in  stream_in,
    fmul_stream_if.out stream_out
);

    mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        MODE inside {0, 1});

    generate
        if (MODE == 0) begin : g_pass
            assign stream_out.valid   = stream_in.valid;
            assign stream_out.payload = stream_in.payload;
            assign stream_in.ready    = stream_out.ready;
        end else begin : g_reg
            logic full;
            T     data;

            // slot frees up in the same cycle it drains
            assign stream_in.ready = !full || stream_out.ready;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    full <= 1'b0;
                end else if (stream_in.ready) begin
                    full <= stream_in.valid;
                end
            end

            always_ff @(posedge clk) begin
                if (stream_in.valid && stream_in.ready) begin
                    data <= stream_in.payload;
                end
            end

            assign stream_out.valid   = full;
            assign stream_out.payload = data;

            held_stable: assert property (@(posedge clk) disable iff (!rst_n)
                stream_out.valid && !stream_out.ready
                |=> stream_out.valid && $stable(stream_out.payload));
        end
    endgenerate

endmodule

//--- logic/fmul_normalize.sv
module fmul_normalize
    import fmul_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input logic clk,
    input logic rst_n,

    fmul_stream_if.in  normalize_cmd,
    fmul_stream_if.out result
);

    localparam int EXP_MAX = 254;
    localparam int EXP_MIN = 1;

    fmul_stream_if #(.T(fmul_result_t)) next_result ();

    fmul_normalize_cmd_t          cmd_in;
    fmul_result_t                 res;
    logic [FMUL_PROD_W-1:0]       prod;
    logic signed [FMUL_EXP_W-1:0] exp_in;
    logic signed [FMUL_EXP_W-1:0] exp_norm;
    logic signed [FMUL_EXP_W-1:0] exp_rnd;
    logic [FMUL_SIG_W-1:0]        mant;
    logic [FMUL_SIG_W:0]          mant_rnd;
    logic [FMUL_SIG_W-2:0]        frac;
    logic                         guard;
    logic                         sticky;
    logic                         round_up;

    assign cmd_in = normalize_cmd.payload;
    assign prod   = cmd_in.product;
    assign exp_in = cmd_in.exp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // normalize and round to nearest even

    always_comb begin
        if (prod[FMUL_PROD_W-1]) begin
            mant   = prod[47:24];
            guard  = prod[23];
            sticky = |prod[22:0];
        end else begin
            mant   = prod[46:23];
            guard  = prod[22];
            sticky = |prod[21:0];
        end
        exp_norm = exp_in + FMUL_EXP_W'(prod[FMUL_PROD_W-1]);

        round_up = guard && (sticky || mant[0]);
        mant_rnd = {1'b0, mant} + {{FMUL_SIG_W{1'b0}}, round_up};

        // a carry out leaves 1.000... with an all-zero fraction
        exp_rnd = exp_norm + FMUL_EXP_W'(mant_rnd[FMUL_SIG_W]);
        frac    = mant_rnd[FMUL_SIG_W-2:0];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // range checks and special overrides

    always_comb begin
        res.tag             = cmd_in.tag;
        res.flags.invalid   = cmd_in.invalid;
        res.flags.overflow  = 1'b0;
        res.flags.underflow = 1'b0;
        res.flags.inexact   = guard || sticky;
        res.result          = {cmd_in.sign, exp_rnd[7:0], frac};

        if (int'(exp_rnd) > EXP_MAX) begin
            res.result          = {cmd_in.sign, 8'hff, 23'h0};
            res.flags.overflow  = 1'b1;
            res.flags.inexact   = 1'b1;
        end else if (int'(exp_rnd) < EXP_MIN) begin
            // flush to zero, no subnormal output
            res.result          = {cmd_in.sign, 31'h0};
            res.flags.underflow = 1'b1;
            res.flags.inexact   = 1'b1;
        end

        if (cmd_in.special != FMUL_SPECIAL_NONE) begin
            res.flags.overflow  = 1'b0;
            res.flags.underflow = 1'b0;
            res.flags.inexact   = 1'b0;
        end
        case (cmd_in.special)
            FMUL_SPECIAL_NAN:  res.result = FMUL_QNAN;
            FMUL_SPECIAL_INF:  res.result = {cmd_in.sign, 8'hff, 23'h0};
            FMUL_SPECIAL_ZERO: res.result = {cmd_in.sign, 31'h0};
            default: ;
        endcase
    end

    assign next_result.valid   = normalize_cmd.valid;
    assign next_result.payload = res;
    assign normalize_cmd.ready = next_result.ready;

    // product of two 1.x significands is in [1, 4)
    prod_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        normalize_cmd.valid && cmd_in.special == FMUL_SPECIAL_NONE
        |-> |prod[FMUL_PROD_W-1 -: 2]);

    fmul_flow_stage #(
        .T(fmul_result_t),
        .MODE(OUTPUT_REGISTER_MODE)
    ) output_stage (
        .clk,
        .rst_n,
        .stream_in(next_result),
        .stream_out(result)
    );

endmodule

//--- logic/fmul_operation.sv
module fmul_operation
    import fmul_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input logic clk,
    input logic rst_n,

    fmul_stream_if.in  operation_cmd,
    fmul_stream_if.out normalize_cmd
);

    fmul_stream_if #(.T(fmul_normalize_cmd_t)) next_normalize_cmd ();

    fmul_operation_cmd_t cmd_in;
    fmul_normalize_cmd_t cmd;

    assign cmd_in = operation_cmd.payload;

    always_comb begin
        cmd.sign    = cmd_in.sign;
        cmd.exp     = cmd_in.exp;
        cmd.product = FMUL_PROD_W'(cmd_in.sig_a) * FMUL_PROD_W'(cmd_in.sig_b);
        cmd.special = cmd_in.special;
        cmd.invalid = cmd_in.invalid;
        cmd.tag     = cmd_in.tag;
    end

    assign next_normalize_cmd.valid   = operation_cmd.valid;
    assign next_normalize_cmd.payload = cmd;
    assign operation_cmd.ready        = next_normalize_cmd.ready;

    // stage 1 only lets normal operands through without a special code
    hidden_bits: assert property (@(posedge clk) disable iff (!rst_n)
        operation_cmd.valid && cmd_in.special == FMUL_SPECIAL_NONE
        |-> cmd_in.sig_a[FMUL_SIG_W-1] && cmd_in.sig_b[FMUL_SIG_W-1]);

    fmul_flow_stage #(
        .T(fmul_normalize_cmd_t),
        .MODE(OUTPUT_REGISTER_MODE)
    ) output_stage (
        .clk,
        .rst_n,
        .stream_in(next_normalize_cmd),
        .stream_out(normalize_cmd)
    );

endmodule

//--- logic/fmul_pkg.sv
package fmul_pkg;

    localparam int FMUL_EXP_W  = 10;
    localparam int FMUL_SIG_W  = 24;
    localparam int FMUL_PROD_W = 2 * FMUL_SIG_W;

    localparam int          FMUL_BIAS = 127;
    localparam logic [31:0] FMUL_QNAN = 32'h7fc0_0000;

    typedef logic [7:0] fmul_tag_t;

    typedef enum logic [1:0] {
        FMUL_CLASS_ZERO,
        FMUL_CLASS_NORMAL,
        FMUL_CLASS_INF,
        FMUL_CLASS_NAN
    } fmul_class_t;

    // result forced by the operand classes, none means compute it
    typedef enum logic [1:0] {
        FMUL_SPECIAL_NONE,
        FMUL_SPECIAL_ZERO,
        FMUL_SPECIAL_INF,
        FMUL_SPECIAL_NAN
    } fmul_special_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fmul_flags_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        fmul_tag_t   tag;
    } fmul_exponent_cmd_t;

    typedef struct packed {
        logic                         sign;
        logic signed [FMUL_EXP_W-1:0] exp;
        logic [FMUL_SIG_W-1:0]        sig_a;
        logic [FMUL_SIG_W-1:0]        sig_b;
        fmul_special_t                special;
        logic                         invalid;
        fmul_tag_t                    tag;
    } fmul_operation_cmd_t;

    typedef struct packed {
        logic                         sign;
        logic signed [FMUL_EXP_W-1:0] exp;
        logic [FMUL_PROD_W-1:0]       product;
        fmul_special_t                special;
        logic                         invalid;
        fmul_tag_t                    tag;
    } fmul_normalize_cmd_t;

    typedef struct packed {
        logic [31:0] result;
        fmul_flags_t flags;
        fmul_tag_t   tag;
    } fmul_result_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand helpers

    // subnormals land in the zero class
    function automatic fmul_class_t fmul_classify(input logic [31:0] op);
        if (op[30:23] == 8'h00) begin
            return FMUL_CLASS_ZERO;
        end
        if (op[30:23] != 8'hff) begin
            return FMUL_CLASS_NORMAL;
        end
        return (op[22:0] == '0) ? FMUL_CLASS_INF : FMUL_CLASS_NAN;
    endfunction

    function automatic logic [FMUL_SIG_W-1:0] fmul_significand(input logic [31:0] op);
        return {|op[30:23], op[22:0]};
    endfunction

endpackage

//--- logic/fmul_stream_if.sv
interface fmul_stream_if #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     payload;

    // consumer side
    modport in (
        input  valid,
        input  payload,
        output ready
    );

    // producer side
    modport out (
        output valid,
        output payload,
        input  ready
    );

endinterface

//--- logic/fmul_top.sv
module fmul_top
    import fmul_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_a,
    input  logic [31:0] in_b,
    input  fmul_tag_t   in_tag,

    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_result,
    output fmul_flags_t out_flags,
    output fmul_tag_t   out_tag
);

    fmul_stream_if #(.T(fmul_exponent_cmd_t))  exponent_cmd ();
    fmul_stream_if #(.T(fmul_operation_cmd_t)) operation_cmd ();
    fmul_stream_if #(.T(fmul_normalize_cmd_t)) normalize_cmd ();
    fmul_stream_if #(.T(fmul_result_t))        result ();

    // request side
    assign exponent_cmd.valid       = in_valid;
    assign exponent_cmd.payload.a   = in_a;
    assign exponent_cmd.payload.b   = in_b;
    assign exponent_cmd.payload.tag = in_tag;
    assign in_ready                 = exponent_cmd.ready;

    fmul_exponent #(.OUTPUT_REGISTER_MODE(OUTPUT_REGISTER_MODE)) exponent_stage (
        .clk, .rst_n, .exponent_cmd, .operation_cmd
    );

    fmul_operation #(.OUTPUT_REGISTER_MODE(OUTPUT_REGISTER_MODE)) operation_stage (
        .clk, .rst_n, .operation_cmd, .normalize_cmd
    );

    fmul_normalize #(.OUTPUT_REGISTER_MODE(OUTPUT_REGISTER_MODE)) normalize_stage (
        .clk, .rst_n, .normalize_cmd, .result
    );

    // response side
    assign out_valid    = result.valid;
    assign result.ready = out_ready;
    assign out_result   = result.payload.result;
    assign out_flags    = result.payload.flags;
    assign out_tag      = result.payload.tag;

endmodule

//--- tests/fmul_ref_model.svh
`ifndef FMUL_REF_MODEL_SVH
`define FMUL_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-precision multiply, round to nearest even
// subnormal inputs and outputs read as zero
// returns {result, invalid, overflow, underflow, inexact}

function automatic logic [35:0] ref_multiply(input logic [31:0] a, input logic [31:0] b);
    int              exp_a;
    int              exp_b;
    int              exp_r;
    int              shift;
    logic            sign;
    logic            a_nan;
    logic            b_nan;
    logic            a_inf;
    logic            b_inf;
    logic            a_zero;
    logic            b_zero;
    longint unsigned sig_a;
    longint unsigned sig_b;
    longint unsigned prod;
    longint unsigned kept;
    longint unsigned rest;
    longint unsigned half;

    sign   = a[31] ^ b[31];
    exp_a  = a[30:23];
    exp_b  = b[30:23];
    a_nan  = (exp_a == 255) && (a[22:0] != 0);
    b_nan  = (exp_b == 255) && (b[22:0] != 0);
    a_inf  = (exp_a == 255) && (a[22:0] == 0);
    b_inf  = (exp_b == 255) && (b[22:0] == 0);
    a_zero = (exp_a == 0);
    b_zero = (exp_b == 0);

    if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
        return {32'h7fc0_0000, 4'b1000};
    end
    if (a_inf || b_inf) begin
        return {sign, 8'hff, 23'h0, 4'b0000};
    end
    if (a_zero || b_zero) begin
        return {sign, 31'h0, 4'b0000};
    end

    sig_a = {1'b1, a[22:0]};
    sig_b = {1'b1, b[22:0]};
    prod  = sig_a * sig_b;

    // keep 24 significant bits, the remainder decides rounding
    shift = prod[47] ? 24 : 23;
    exp_r = exp_a + exp_b - 127 + shift - 23;
    kept  = prod >> shift;
    rest  = prod - (kept << shift);
    half  = 64'd1 << (shift - 1);
    if (rest > half || (rest == half && kept[0])) begin
        kept = kept + 1;
    end
    if (kept[24]) begin
        kept  = kept >> 1;
        exp_r = exp_r + 1;
    end

    if (exp_r > 254) begin
        return {sign, 8'hff, 23'h0, 4'b0101};
    end
    if (exp_r < 1) begin
        return {sign, 31'h0, 4'b0011};
    end
    return {sign, exp_r[7:0], kept[22:0], 3'b000, rest != 0};
endfunction

`endif

//--- tests/fmul_tb.sv
module fmul_tb
    import fmul_pkg::*;
;

    `include "fmul_ref_model.svh"

    localparam int N_NORMAL  = 7;
    localparam int N_SPECIAL = 9;
    localparam int N_RANGE   = 5;
    localparam int N_TIMING  = 16;
    localparam int N_RANDOM  = 400;
    localparam int N_REQUESTS = N_NORMAL + N_SPECIAL + N_RANGE + N_TIMING + N_RANDOM;
    localparam int WATCHDOG_TIME = N_REQUESTS * 40 + 2000;

    // 1.5*2, 3*-0.5, 1.5*1.5, two ties (up to even, down to even), two inexact
    localparam logic [31:0] NORMAL_A [N_NORMAL] = '{32'h3fc00000, 32'h40400000, 32'h3fc00000,
        32'h3f800001, 32'h3f800003, 32'h3f8ccccd, 32'h40490fdb};
    localparam logic [31:0] NORMAL_B [N_NORMAL] = '{32'h40000000, 32'hbf000000, 32'h3fc00000,
        32'h3fc00000, 32'h3fc00000, 32'h3f8ccccd, 32'h402df854};
    localparam logic [31:0] SPECIAL_A [N_SPECIAL] = '{32'h7fc00000, 32'h7f800001, 32'hff800000,
        32'h00000000, 32'h7f800000, 32'h3f800000, 32'h80000000, 32'h00400000, 32'h00000001};
    localparam logic [31:0] SPECIAL_B [N_SPECIAL] = '{32'h3f800000, 32'h40000000, 32'h00000000,
        32'h7f800000, 32'hc0000000, 32'hff800000, 32'h3f800000, 32'hc0000000, 32'h7f800000};
    localparam logic [31:0] RANGE_A [N_RANGE] = '{32'h7f000000, 32'hff7fffff, 32'h7f7fffff,
        32'h00800000, 32'h80800000};
    localparam logic [31:0] RANGE_B [N_RANGE] = '{32'h40000000, 32'h7f7fffff, 32'h3f800001,
        32'h3f000000, 32'h00800000};

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_a;
    logic [31:0] in_b;
    fmul_tag_t   in_tag;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_result;
    fmul_flags_t out_flags;
    fmul_tag_t   out_tag;

    // expected {result, flags, tag} of every request inside the DUT
    logic [43:0] exp_q[$];
    logic [31:0] exp_result;
    logic [3:0]  exp_flags;
    fmul_tag_t   exp_tag;
    int          in_flight;
    int          accepted;
    int          checks;
    int          errors;
    int          errors_at_start;
    int          tests;
    fmul_tag_t   next_tag;
    logic        timing_mode;

    fmul_top #(.OUTPUT_REGISTER_MODE(1)) dut0 (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_a, .in_b, .in_tag,
        .out_valid, .out_ready, .out_result, .out_flags, .out_tag
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("FAIL: see errors above");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard and checks

    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                checks++;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back({ref_multiply(in_a, in_b), in_tag});
                accepted++;
            end
            in_flight = exp_q.size();
            if (in_flight > 0) begin
                {exp_result, exp_flags, exp_tag} = exp_q[0];
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    result_ok: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && in_flight > 0 |-> out_result == exp_result)
        else report_mismatch("out_result", $sampled(exp_result), $sampled(out_result));

    flags_ok: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && in_flight > 0 |-> out_flags == exp_flags)
        else report_mismatch("out_flags", 32'($sampled(exp_flags)), 32'($sampled(out_flags)));

    tag_ok: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && in_flight > 0 |-> out_tag == exp_tag)
        else report_mismatch("out_tag", 32'($sampled(exp_tag)), 32'($sampled(out_tag)));

    no_extra_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> in_flight > 0)
        else report_failure("output transfer with no request outstanding");

    full_when_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready |-> in_flight == 3)
        else report_failure("in_ready low with fewer than three items held");

    held_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result)
            && $stable(out_flags) && $stable(out_tag))
        else report_failure("output changed while out_ready was low");

    latency_three: assert property (@(posedge clk) disable iff (!rst_n)
        timing_mode && in_valid && in_ready |-> ##3 (out_valid && out_tag == $past(in_tag, 3)))
        else report_failure("result did not appear 3 cycles after its input transfer");

    no_gap: assert property (@(posedge clk) disable iff (!rst_n)
        timing_mode |-> in_ready)
        else report_failure("in_ready dropped with out_ready held high");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus

    // starts at a falling edge, returns at the falling edge after the transfer
    task automatic send(input logic [31:0] a, input logic [31:0] b);
        int taken;
        taken    = accepted;
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        in_tag   = next_tag;
        do begin
            @(negedge clk);
        end while (accepted == taken);
        in_valid = 1'b0;
        next_tag = next_tag + 1;
    endtask

    task automatic drain();
        while (in_flight > 0) begin
            @(negedge clk);
        end
    endtask

    function automatic logic [31:0] normal_operand();
        logic [31:0] op;
        op        = $urandom();
        op[30:23] = 8'($urandom_range(110, 144));
        return op;
    endfunction

    // mostly moderate exponents, some raw patterns and special encodings
    function automatic logic [31:0] random_operand();
        logic [31:0] op;
        int          pick;
        op   = $urandom();
        pick = $urandom_range(0, 7);
        if (pick == 1) begin
            op[30:23] = ($urandom_range(0, 1) == 1) ? 8'hff : 8'h00;
        end else if (pick > 1) begin
            op[30:23] = 8'($urandom_range(100, 154));
        end
        return op;
    endfunction

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic random_traffic();
        logic feeding;
        feeding = 1'b1;
        fork
            begin
                while (feeding) begin
                    out_ready = ($urandom_range(0, 2) != 0);
                    @(negedge clk);
                end
                out_ready = 1'b1;
            end
            begin
                for (int i = 0; i < N_RANDOM; i++) begin
                    send(random_operand(), random_operand());
                    if ($urandom_range(0, 7) == 0) begin
                        @(negedge clk);
                    end
                end
                feeding = 1'b0;
            end
        join
        drain();
        assert (checks == accepted)
            else report_failure("number of results differs from number of requests");
    endtask

    initial begin
        void'($urandom(32'h2031_7c2a));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        in_tag      = '0;
        out_ready   = 1'b1;
        next_tag    = '0;
        timing_mode = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        assert (!out_valid && in_ready)
            else report_failure("out_valid or in_ready wrong after reset");
        end_test("reset");

        for (int i = 0; i < N_NORMAL; i++) begin
            send(NORMAL_A[i], NORMAL_B[i]);
        end
        drain();
        end_test("normal");

        for (int i = 0; i < N_SPECIAL; i++) begin
            send(SPECIAL_A[i], SPECIAL_B[i]);
        end
        drain();
        end_test("special");

        for (int i = 0; i < N_RANGE; i++) begin
            send(RANGE_A[i], RANGE_B[i]);
        end
        drain();
        end_test("range");

        timing_mode = 1'b1;
        for (int i = 0; i < N_TIMING; i++) begin
            send(normal_operand(), normal_operand());
        end
        drain();
        repeat (2) @(negedge clk);
        timing_mode = 1'b0;
        end_test("timing");

        random_traffic();
        end_test("random");

        $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
